/* fetch_unit.f */
src/fetch_pkg.sv
src/icache_mem_if.sv
src/fetch_if.sv
src/icache_mem.sv
src/icache_ctrl.sv
src/fetch_stage.sv
src/fetch_buffer.sv
src/fetch_unit.sv
tests/tb_mem_model.sv
tests/fetch_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module fetch_unit_tb \
  -f fetch_unit.f -o fetch_unit_sim > build.log 2>&1 &&
  ./obj_dir/fetch_unit_sim > sim.log 2>&1 ||
  { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

/* src/fetch_buffer.sv */
module fetch_buffer (
  input  logic                         clock,
  input  logic                         rst,
  input  logic                         redirect_en,
  input  logic                         inst_ready,
  output logic                         inst_valid,
  output logic [fetch_pkg::ADDR_W-1:0] inst_pc,
  output logic [fetch_pkg::INST_W-1:0] inst_ir,
  fetch_if.dst                         fi
);

  logic [fetch_pkg::ADDR_W-1:0] pc_q [fetch_pkg::FB_DEPTH];
  logic [fetch_pkg::INST_W-1:0] ir_q [fetch_pkg::FB_DEPTH];

  logic [fetch_pkg::FB_PTR_W-1:0] head;
  logic [fetch_pkg::FB_PTR_W-1:0] tail;
  logic [fetch_pkg::FB_PTR_W:0]   count;  // One extra bit for full
  logic                           push;
  logic                           pop;

  assign fi.ready   = (count != fetch_pkg::FB_DEPTH);
  assign inst_valid = (count != '0);
  assign inst_pc    = pc_q[head];
  assign inst_ir    = ir_q[head];

  assign push = fi.valid && fi.ready;
  assign pop  = inst_valid && inst_ready;

  always_ff @(posedge clock) begin
    if (rst || redirect_en) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= tail + 1'b1;
      if (pop)  head <= head + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      pc_q[tail] <= fi.pc;
      ir_q[tail] <= fi.ir;
    end
  end

endmodule

/* src/fetch_if.sv */
interface fetch_if;

  logic                         valid;
  logic [fetch_pkg::ADDR_W-1:0] pc;
  logic [fetch_pkg::INST_W-1:0] ir;
  logic                         ready;  // Buffer not full

  modport src (
    output valid, pc, ir,
    input  ready
  );

  modport dst (
    input  valid, pc, ir,
    output ready
  );

endinterface

/* src/fetch_pkg.sv */
package fetch_pkg;

  // Bus and datapath widths
  localparam int ADDR_W    = 64;
  localparam int DATA_W    = 64;
  localparam int INST_W    = 32;
  localparam int MEM_TAG_W = 4;

  // Direct-mapped I-cache geometry, 8-byte lines
  localparam int CACHE_LINES = 32;
  localparam int IDX_W       = 5;
  localparam int CACHE_TAG_W = 8;
  localparam int OFFSET_W    = 3;

  // Fetch buffer
  localparam int FB_DEPTH = 8;
  localparam int FB_PTR_W = 3;  // log2 of FB_DEPTH

  localparam logic [ADDR_W-1:0] RESET_PC = '0;

  // Memory bus commands
  typedef enum logic [1:0] {
    BUS_NONE = 2'd0,
    BUS_LOAD = 2'd1
  } bus_cmd_e;

  // I-cache controller
  typedef enum logic [1:0] {
    IDLE,
    WAIT_RESP,  // load on the bus until accepted
    WAIT_DATA   // waiting for matching data tag
  } ctrl_state_e;

endpackage

/* src/fetch_stage.sv */
module fetch_stage (
  input  logic                         clock,
  input  logic                         rst,
  input  logic                         redirect_en,
  input  logic [fetch_pkg::ADDR_W-1:0] redirect_pc,
  input  logic                         hit,
  input  logic [fetch_pkg::DATA_W-1:0] line,
  output logic [fetch_pkg::ADDR_W-1:0] fetch_pc,
  fetch_if.src                         fo
);

  logic [fetch_pkg::ADDR_W-1:0] pc;
  logic                         xfer;

  assign fetch_pc = pc;

  // Nothing goes out in a redirect cycle
  assign fo.valid = hit && !redirect_en;
  assign fo.pc    = pc;
  assign fo.ir    = pc[2] ? line[2*fetch_pkg::INST_W-1:fetch_pkg::INST_W]
                          : line[fetch_pkg::INST_W-1:0];

  assign xfer = fo.valid && fo.ready;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= fetch_pkg::RESET_PC;
    end else if (redirect_en) begin
      pc <= redirect_pc;
    end else if (xfer) begin
      pc <= pc + 4;  // Scalar, next word
    end
  end

endmodule

/* src/fetch_unit.sv */
module fetch_unit (
  input  logic                            clock,
  input  logic                            rst,
  input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_response,
  input  logic [fetch_pkg::DATA_W-1:0]    mem2proc_data,
  input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_tag,
  input  logic                            redirect_en,
  input  logic [fetch_pkg::ADDR_W-1:0]    redirect_pc,
  input  logic                            inst_ready,
  output fetch_pkg::bus_cmd_e             proc2mem_command,
  output logic [fetch_pkg::ADDR_W-1:0]    proc2mem_addr,
  output logic                            inst_valid,
  output logic [fetch_pkg::ADDR_W-1:0]    inst_pc,
  output logic [fetch_pkg::INST_W-1:0]    inst_ir
);

  logic [fetch_pkg::ADDR_W-1:0] fetch_pc;
  logic                         hit;
  logic [fetch_pkg::DATA_W-1:0] line;

  icache_mem_if cmem_bus ();
  fetch_if      fetch_bus ();

  icache_mem i_icache_mem (
    .clock (clock),
    .rst   (rst),
    .mem   (cmem_bus.mem)
  );

  icache_ctrl i_icache_ctrl (
    .clock             (clock),
    .rst               (rst),
    .fetch_pc          (fetch_pc),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .hit               (hit),
    .line              (line),
    .cmem              (cmem_bus.ctrl)
  );

  fetch_stage i_fetch_stage (
    .clock       (clock),
    .rst         (rst),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .hit         (hit),
    .line        (line),
    .fetch_pc    (fetch_pc),
    .fo          (fetch_bus.src)
  );

  // Flushed on redirect
  fetch_buffer i_fetch_buffer (
    .clock       (clock),
    .rst         (rst),
    .redirect_en (redirect_en),
    .inst_ready  (inst_ready),
    .inst_valid  (inst_valid),
    .inst_pc     (inst_pc),
    .inst_ir     (inst_ir),
    .fi          (fetch_bus.dst)
  );

endmodule

/* src/icache_ctrl.sv */
module icache_ctrl (
  input  logic                            clock,
  input  logic                            rst,
  input  logic [fetch_pkg::ADDR_W-1:0]    fetch_pc,
  input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_response,
  input  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_tag,
  input  logic [fetch_pkg::DATA_W-1:0]    mem2proc_data,
  output fetch_pkg::bus_cmd_e             proc2mem_command,
  output logic [fetch_pkg::ADDR_W-1:0]    proc2mem_addr,
  output logic                            hit,
  output logic [fetch_pkg::DATA_W-1:0]    line,
  icache_mem_if.ctrl                      cmem
);

  fetch_pkg::ctrl_state_e state, state_next;

  logic [fetch_pkg::IDX_W-1:0]       miss_idx;
  logic [fetch_pkg::CACHE_TAG_W-1:0] miss_tag;
  logic [fetch_pkg::MEM_TAG_W-1:0]   req_tag;   // Tag the memory accepted the load under
  logic [fetch_pkg::ADDR_W-1:0]      miss_addr;
  logic                              accepted;
  logic                              data_back;

  // Address split for lookup
  assign cmem.rd_idx = fetch_pc[fetch_pkg::OFFSET_W +: fetch_pkg::IDX_W];
  assign cmem.rd_tag = fetch_pc[fetch_pkg::OFFSET_W + fetch_pkg::IDX_W +: fetch_pkg::CACHE_TAG_W];

  assign hit  = cmem.rd_hit;
  assign line = cmem.rd_data;

  // Line-aligned request address
  assign miss_addr = {
    {(fetch_pkg::ADDR_W - fetch_pkg::CACHE_TAG_W - fetch_pkg::IDX_W - fetch_pkg::OFFSET_W){1'b0}},
    miss_tag,
    miss_idx,
    {fetch_pkg::OFFSET_W{1'b0}}
  };

  assign accepted  = (state == fetch_pkg::WAIT_RESP) && (mem2proc_response != '0);
  assign data_back = (state == fetch_pkg::WAIT_DATA) && (mem2proc_tag == req_tag);

  assign proc2mem_command = (state == fetch_pkg::WAIT_RESP) ? fetch_pkg::BUS_LOAD
                                                            : fetch_pkg::BUS_NONE;
  assign proc2mem_addr    = (state == fetch_pkg::WAIT_RESP) ? miss_addr : '0;

  // Fill goes into the latched line, never the current PC
  assign cmem.wr_en   = data_back;
  assign cmem.wr_idx  = miss_idx;
  assign cmem.wr_tag  = miss_tag;
  assign cmem.wr_data = mem2proc_data;

  always_comb begin
    state_next = state;
    case (state)
      fetch_pkg::IDLE:      if (!cmem.rd_hit) state_next = fetch_pkg::WAIT_RESP;
      fetch_pkg::WAIT_RESP: if (accepted) state_next = fetch_pkg::WAIT_DATA;
      fetch_pkg::WAIT_DATA: if (data_back) state_next = fetch_pkg::IDLE;
      default:              state_next = fetch_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= fetch_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (state == fetch_pkg::IDLE && !cmem.rd_hit) begin
      miss_idx <= cmem.rd_idx;
      miss_tag <= cmem.rd_tag;
    end
    if (accepted) begin
      req_tag <= mem2proc_response;
    end
  end

endmodule

/* src/icache_mem.sv */
module icache_mem (
  input logic        clock,
  input logic        rst,
  icache_mem_if.mem  mem
);

  logic [fetch_pkg::DATA_W-1:0]      data_q [fetch_pkg::CACHE_LINES];
  logic [fetch_pkg::CACHE_TAG_W-1:0] tag_q  [fetch_pkg::CACHE_LINES];
  logic [fetch_pkg::CACHE_LINES-1:0] valid_q;

  // Combinational lookup
  assign mem.rd_data = data_q[mem.rd_idx];
  assign mem.rd_hit  = valid_q[mem.rd_idx] && (tag_q[mem.rd_idx] == mem.rd_tag);

  always_ff @(posedge clock) begin
    if (rst) begin
      valid_q <= '0;
    end else if (mem.wr_en) begin
      valid_q[mem.wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (mem.wr_en) begin
      data_q[mem.wr_idx] <= mem.wr_data;
      tag_q[mem.wr_idx]  <= mem.wr_tag;
    end
  end

endmodule

/* src/icache_mem_if.sv */
interface icache_mem_if;

  // Lookup side
  logic [fetch_pkg::IDX_W-1:0]       rd_idx;
  logic [fetch_pkg::CACHE_TAG_W-1:0] rd_tag;
  logic [fetch_pkg::DATA_W-1:0]      rd_data;
  logic                              rd_hit;

  // Fill side
  logic                              wr_en;
  logic [fetch_pkg::IDX_W-1:0]       wr_idx;
  logic [fetch_pkg::CACHE_TAG_W-1:0] wr_tag;
  logic [fetch_pkg::DATA_W-1:0]      wr_data;

  modport ctrl (
    output rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_data,
    input  rd_data, rd_hit
  );

  modport mem (
    input  rd_idx, rd_tag, wr_en, wr_idx, wr_tag, wr_data,
    output rd_data, rd_hit
  );

endinterface

/* tests/fetch_unit_tb.sv */
module fetch_unit_tb;

  localparam int          PHASE_LEN      = 1000;
  localparam int          TOTAL_INSTS    = 2 * PHASE_LEN;
  localparam int          TIMEOUT_CYCLES = TOTAL_INSTS * 40;
  localparam logic [31:0] SEED           = 32'h2fa0910a;
  localparam logic [63:0] LOW_PC_LIMIT   = 64'd192;  // Lookahead stays under 256

  logic                            clock;
  logic                            rst;
  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_response;
  logic [fetch_pkg::DATA_W-1:0]    mem2proc_data;
  logic [fetch_pkg::MEM_TAG_W-1:0] mem2proc_tag;
  logic                            redirect_en;
  logic [fetch_pkg::ADDR_W-1:0]    redirect_pc;
  logic                            inst_ready;
  fetch_pkg::bus_cmd_e             proc2mem_command;
  logic [fetch_pkg::ADDR_W-1:0]    proc2mem_addr;
  logic                            inst_valid;
  logic [fetch_pkg::ADDR_W-1:0]    inst_pc;
  logic [fetch_pkg::INST_W-1:0]    inst_ir;

  integer seed;
  int     consumed     = 0;
  int     loads        = 0;
  int     late_loads   = 0;
  int     value_errors = 0;
  int     other_errors = 0;
  int     cycles       = 0;
  int     phase        = 1;

  // Reference model state
  logic [fetch_pkg::ADDR_W-1:0]      exp_pc;
  logic                              after_redirect;
  logic                              force_redirect;
  logic                              held = 1'b0;
  logic [fetch_pkg::ADDR_W-1:0]      held_pc;
  logic [fetch_pkg::INST_W-1:0]      held_ir;
  logic                              outstanding = 1'b0;
  logic [fetch_pkg::MEM_TAG_W-1:0]   out_tag;
  logic [fetch_pkg::ADDR_W-1:0]      out_addr;
  logic [fetch_pkg::CACHE_LINES-1:0] res_valid = '0;
  logic [fetch_pkg::CACHE_TAG_W-1:0] res_tag [fetch_pkg::CACHE_LINES];

  fetch_unit i_dut (
    .clock             (clock),
    .rst               (rst),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .redirect_en       (redirect_en),
    .redirect_pc       (redirect_pc),
    .inst_ready        (inst_ready),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .inst_valid        (inst_valid),
    .inst_pc           (inst_pc),
    .inst_ir           (inst_ir)
  );

  tb_mem_model #(.SEED(SEED)) i_mem (
    .clock    (clock),
    .rst      (rst),
    .command  (proc2mem_command),
    .addr     (proc2mem_addr),
    .response (mem2proc_response),
    .tag      (mem2proc_tag),
    .data     (mem2proc_data)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] mem_word(input logic [fetch_pkg::ADDR_W-1:0] a);
    return a[31:0] * 32'h9e3779b1 + 32'd1;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Index is bits 7:3, tag bits 15:8
  function automatic logic is_resident(input logic [fetch_pkg::ADDR_W-1:0] a);
    return res_valid[a[7:3]] && (res_tag[a[7:3]] == a[15:8]);
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    value_errors++;
    $display("ERR %s: expected %h, actual %h", name, expected, actual);
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("%s", what);
  endtask

  task automatic print_counts();
    $display("consumed %0d, loads %0d (phase 2 %0d), value errors %0d, other errors %0d",
             consumed, loads, late_loads, value_errors, other_errors);
  endtask

  task automatic sample_and_drive();
    logic                         ready;
    logic                         redir;
    logic [fetch_pkg::ADDR_W-1:0] target;
    if (held) begin
      assert (inst_valid) else report_failure("stalled instruction vanished before it was taken");
      assert (inst_pc == held_pc) else report_mismatch("stall hold pc", held_pc, inst_pc);
      assert (inst_ir == held_ir) else report_mismatch("stall hold ir", 64'(held_ir), 64'(inst_ir));
    end
    ready  = (rand_below(3) != 0);
    redir  = !redirect_en && (force_redirect || rand_below(40) == 0);
    target = '0;
    if (phase == 1) begin
      target[13:2] = 12'(rand_below(4096));  // Below 16 KiB
    end else begin
      target[6:2] = 5'(rand_below(32));
    end
    // Pop is lost when the buffer flushes on the same edge
    if (inst_valid && ready && !redir) begin
      if (after_redirect) begin
        assert (inst_pc == exp_pc) else report_mismatch("redirect target pc", exp_pc, inst_pc);
      end else begin
        assert (inst_pc == exp_pc) else report_mismatch("sequential pc", exp_pc, inst_pc);
      end
      assert (inst_ir == mem_word(exp_pc))
        else report_mismatch("instruction word", 64'(mem_word(exp_pc)), 64'(inst_ir));
      exp_pc         = exp_pc + 4;
      after_redirect = 1'b0;
      consumed++;
    end
    if (redir) begin
      exp_pc         = target;
      after_redirect = 1'b1;
      force_redirect = 1'b0;
    end
    held    = inst_valid && !ready && !redir;
    held_pc = inst_pc;
    held_ir = inst_ir;
    if (phase == 1 && consumed >= PHASE_LEN) begin
      phase          = 2;
      force_redirect = 1'b1;
    end else if (phase == 2 && exp_pc >= LOW_PC_LIMIT) begin
      force_redirect = 1'b1;
    end
    inst_ready  = ready;
    redirect_en = redir;
    redirect_pc = target;
  endtask

  // Bus monitor sees the values that the DUT samples on this edge
  always @(posedge clock) begin
    if (rst) begin
      outstanding = 1'b0;
      res_valid   = '0;
    end else if (proc2mem_command == fetch_pkg::BUS_LOAD) begin
      assert (proc2mem_addr[2:0] == 3'd0)
        else report_mismatch("load offset bits", 64'd0, 64'(proc2mem_addr[2:0]));
      assert (!outstanding) else report_failure("load issued while another load is outstanding");
      assert (!is_resident(proc2mem_addr))
        else report_failure("load issued for a line that is already resident");
      if (mem2proc_response != '0) begin
        outstanding = 1'b1;
        out_tag     = mem2proc_response;
        out_addr    = proc2mem_addr;
        loads++;
        if (phase == 2) late_loads++;
      end
    end else if (outstanding && mem2proc_tag == out_tag) begin
      res_valid[out_addr[7:3]] = 1'b1;
      res_tag[out_addr[7:3]]   = out_addr[15:8];
      outstanding              = 1'b0;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: only %0d of %0d instructions consumed after %0d cycles",
               consumed, TOTAL_INSTS, cycles);
      other_errors++;
      print_counts();
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    seed           = SEED;
    rst            = 1'b1;
    redirect_en    = 1'b0;
    redirect_pc    = '0;
    inst_ready     = 1'b0;
    exp_pc         = fetch_pkg::RESET_PC;
    after_redirect = 1'b0;
    force_redirect = 1'b0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    assert (!inst_valid) else report_failure("inst_valid is high right after reset");
    assert (proc2mem_command == fetch_pkg::BUS_NONE)
      else report_failure("memory command is active right after reset");
    rst = 1'b0;
    while (consumed < TOTAL_INSTS) begin
      sample_and_drive();
      @(negedge clock);
    end
    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tests/tb_mem_model.sv */
module tb_mem_model #(
  parameter logic [31:0] SEED = 32'h2fa0910a
) (
  input  logic                            clock,
  input  logic                            rst,
  input  fetch_pkg::bus_cmd_e             command,
  input  logic [fetch_pkg::ADDR_W-1:0]    addr,
  output logic [fetch_pkg::MEM_TAG_W-1:0] response,
  output logic [fetch_pkg::MEM_TAG_W-1:0] tag,
  output logic [fetch_pkg::DATA_W-1:0]    data
);

  integer                          seed;
  logic [fetch_pkg::MEM_TAG_W-1:0] next_tag;
  logic [fetch_pkg::MEM_TAG_W-1:0] busy_tag;
  logic [fetch_pkg::ADDR_W-1:0]    busy_addr;
  int unsigned                     wait_cnt;

  // Word at byte address a
  function automatic logic [31:0] word_at(input logic [fetch_pkg::ADDR_W-1:0] a);
    return a[31:0] * 32'h9e3779b1 + 32'd1;
  endfunction

  initial begin
    seed      = SEED;
    response  = '0;
    tag       = '0;
    data      = '0;
    next_tag  = 4'h1;
    busy_tag  = '0;
    busy_addr = '0;
    wait_cnt  = 0;
  end

  // Outputs change on the falling edge, sampled by the DUT on the rising one
  always @(negedge clock) begin
    if (rst) begin
      response = '0;
      tag      = '0;
      wait_cnt = 0;
    end else begin
      response = '0;
      tag      = '0;
      if (wait_cnt != 0) begin
        wait_cnt = wait_cnt - 1;
        if (wait_cnt == 0) begin
          tag  = busy_tag;
          data = {word_at(busy_addr + 4), word_at(busy_addr)};  // Upper word at +4
        end
      end else if (command == fetch_pkg::BUS_LOAD && ($unsigned($random(seed)) % 4) != 0) begin
        response  = next_tag;
        busy_tag  = next_tag;
        busy_addr = addr;
        wait_cnt  = 2 + ($unsigned($random(seed)) % 7);
        next_tag  = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;  // Zero means reject
      end
    end
  end

endmodule
